// File: bench/qdrii_memctl_tb.sv
// Testbench for the QDRII-style SRAM controller running a request table against a scoreboard
`timescale 1ns/100ps

module qdrii_memctl_tb;

	localparam int aw = memctl_bus_pkg::addr_width;
	localparam int dw = memctl_bus_pkg::data_width;
	localparam int bw = memctl_bus_pkg::burst_width;
	localparam int bl = memctl_timing_pkg::burst_length;

	// Command one cycle after acceptance, then latency, burst, capture and output register
	localparam int valid_delay = 1 + memctl_timing_pkg::read_latency + bl + 1;

	typedef enum logic [1:0] {op_idle, op_read, op_write, op_both} op_t;

	typedef struct packed {
		op_t op;
		logic [aw-1:0] rd_addr;
		logic [aw-1:0] wr_addr;
		logic random_data;
		logic [bw-1:0] data;
	} entry_t;

	logic clk;
	logic reset_n;
	logic rd_req;
	logic [aw-1:0] rd_addr;
	logic rd_ready;
	logic [bw-1:0] rd_data;
	logic rd_valid;
	logic wr_req;
	logic [aw-1:0] wr_addr;
	logic [bw-1:0] wr_data;
	logic wr_ready;
	logic [aw-1:0] mem_addr;
	logic mem_read_n;
	logic mem_write_n;
	logic [dw-1:0] mem_wdata;
	logic [dw-1:0] mem_rdata;

	int cycle_count = 0;
	int timeout_limit;
	// Cycles in which each ready is due back high and each command is due on the pins
	int rd_due;
	int wr_due;
	int rd_cmd_cycle;
	int wr_cmd_cycle;
	logic [aw-1:0] rd_cmd_addr;
	logic [aw-1:0] wr_cmd_addr;
	logic [15:0] lfsr_state;
	logic [bw-1:0] ref_mem [2**aw];
	logic [bw-1:0] exp_data_q [$];
	int exp_cycle_q [$];
	entry_t stim_table [$];

	qdrii_memctl dut (
		.clk(clk), .reset_n(reset_n),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_ready(rd_ready),
		.rd_data(rd_data), .rd_valid(rd_valid),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ready(wr_ready),
		.mem_addr(mem_addr), .mem_read_n(mem_read_n), .mem_write_n(mem_write_n),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	qdrii_memory_model sram (
		.clk(clk), .reset_n(reset_n), .mem_addr(mem_addr),
		.mem_read_n(mem_read_n), .mem_write_n(mem_write_n),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reporting and checks
	////////////////////////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
			$display("Done: errors found");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Ready levels and command pins for the current cycle, sampled 2 ns after the edge
	task automatic check_pins();
		check_value("rd_ready", rd_ready, cycle_count >= rd_due);
		check_value("wr_ready", wr_ready, cycle_count >= wr_due);
		check_value("mem_read_n", mem_read_n, cycle_count != rd_cmd_cycle);
		check_value("mem_write_n", mem_write_n, cycle_count != wr_cmd_cycle);
		if (cycle_count == rd_cmd_cycle)
			check_value("mem_addr", mem_addr, rd_cmd_addr);
		if (cycle_count == wr_cmd_cycle)
			check_value("mem_addr", mem_addr, wr_cmd_addr);
	endtask

	// Cycle counter with the run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
			report_failure($sformatf("Timeout: run did not finish in %0d cycles", cycle_count));
	end

	// Every rd_valid pulse must match the oldest outstanding read
	always @(negedge clk)
	begin
		if (reset_n && rd_valid)
		begin
			if (exp_data_q.size() == 0)
				report_failure("rd_valid pulsed with no read outstanding");
			else
			begin
				check_value("rd_valid cycle", cycle_count, exp_cycle_q.pop_front());
				check_value("rd_data", rd_data, exp_data_q.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [bw-1:0] random_burst();
		logic [bw-1:0] value;
		for (int i = 0; i < bw; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value[i] = lfsr_state[0];
		end
		return value;
	endfunction

	task automatic add_entry(input op_t op, input logic [aw-1:0] ra, input logic [aw-1:0] wa,
		input logic rnd, input logic [bw-1:0] data);
		stim_table.push_back({op, ra, wa, rnd, data});
	endtask

	// One entry takes a cycle, or longer while a request waits for its ready
	task automatic apply_entry(input entry_t e);
		logic want_rd;
		logic want_wr;
		logic rd_acc;
		logic wr_acc;
		int acc_cycle;
		logic [bw-1:0] data;

		want_rd = (e.op == op_read) || (e.op == op_both);
		want_wr = (e.op == op_write) || (e.op == op_both);
		data = e.random_data ? random_burst() : e.data;
		do
		begin
			check_pins();
			// Address and data change only while the port is ready, since the
			// write path takes wr_data in the cycle of its command
			if (rd_ready)
			begin
				rd_req = want_rd;
				rd_addr = e.rd_addr;
			end
			else
				rd_req = rd_req & want_rd;
			if (wr_ready)
			begin
				wr_req = want_wr;
				wr_addr = e.wr_addr;
				wr_data = data;
			end
			else
				wr_req = wr_req & want_wr;
			rd_acc = rd_req & rd_ready;
			wr_acc = wr_req & wr_ready;
			acc_cycle = cycle_count;
			@(posedge clk);
			// The read is scored first, so it sees the data from before a same-cycle write
			if (rd_acc)
			begin
				exp_data_q.push_back(ref_mem[rd_addr]);
				exp_cycle_q.push_back(acc_cycle + valid_delay);
				rd_cmd_cycle = acc_cycle + 1;
				rd_cmd_addr = rd_addr;
				rd_due = acc_cycle + bl;
				want_rd = 1'b0;
			end
			if (wr_acc)
			begin
				ref_mem[wr_addr] = wr_data;
				wr_cmd_cycle = acc_cycle + 1 + int'(rd_acc);
				wr_cmd_addr = wr_addr;
				wr_due = wr_cmd_cycle + bl - 1;
				want_wr = 1'b0;
			end
			#2;
		end
		while (want_rd || want_wr);
	endtask

	initial
	begin
		reset_n = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		wr_req = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_due = 0;
		wr_due = 0;
		rd_cmd_cycle = -1;
		wr_cmd_cycle = -1;
		lfsr_state = 16'd92;
		for (int a = 0; a < 2**aw; a++)
			ref_mem[a] = {bl{dw'(a)}};

		// Each row holds the operation, both addresses, the random data flag and the write data
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h005, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_write, 10'h000, 10'h010, 1'b1, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h010, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h011, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h012, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h013, 10'h000, 1'b0, 36'h0);
		add_entry(op_write, 10'h000, 10'h020, 1'b0, 36'h987654321);
		add_entry(op_write, 10'h000, 10'h021, 1'b1, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_both,  10'h020, 10'h020, 1'b1, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h020, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_both,  10'h3ff, 10'h3ff, 1'b0, 36'h123456789);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h3ff, 10'h000, 1'b0, 36'h0);
		add_entry(op_read,  10'h021, 10'h000, 1'b0, 36'h0);
		add_entry(op_idle,  10'h000, 10'h000, 1'b0, 36'h0);
		timeout_limit = stim_table.size() * 8 + 50;

		repeat (10) @(posedge clk);
		#2 reset_n = 1'b1;
		check_value("rd_valid", rd_valid, 1'b0);

		foreach (stim_table[i])
			apply_entry(stim_table[i]);

		// Let outstanding reads return and the last write burst drain
		check_pins();
		rd_req = 1'b0;
		wr_req = 1'b0;
		while (exp_data_q.size() != 0)
		begin
			@(posedge clk);
			#2;
			check_pins();
		end
		repeat (bl + 2) @(posedge clk);

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: bench/qdrii_memory_model.sv
// Behavioral QDRII-style SRAM with fixed read latency, write capture and an address fill pattern
`timescale 1ns/100ps

module qdrii_memory_model (
	input logic clk,
	input logic reset_n,
	input logic [memctl_bus_pkg::addr_width-1:0] mem_addr,
	input logic mem_read_n,
	input logic mem_write_n,
	input logic [memctl_bus_pkg::data_width-1:0] mem_wdata,
	output logic [memctl_bus_pkg::data_width-1:0] mem_rdata
);

	localparam int aw = memctl_bus_pkg::addr_width;
	localparam int dw = memctl_bus_pkg::data_width;
	localparam int bw = memctl_bus_pkg::burst_width;
	localparam int bl = memctl_timing_pkg::burst_length;
	localparam int rl = memctl_timing_pkg::read_latency;
	localparam int wl = memctl_timing_pkg::write_latency;

	// Stage k of each pipeline holds a command seen k cycles ago
	localparam int rd_depth = rl + bl - 1;
	localparam int wr_depth = wl + bl - 1;

	logic [bw-1:0] mem [2**aw];
	logic rd_valid_sr [1:rd_depth];
	logic [bw-1:0] rd_burst_sr [1:rd_depth];
	logic wr_valid_sr [1:wr_depth];
	logic [aw-1:0] wr_addr_sr [1:wr_depth];

	// Every word of a location starts out as its own address
	initial
	begin
		for (int a = 0; a < 2**aw; a++)
			mem[a] = {bl{dw'(a)}};
	end

	////////////////////////////////////////////////////////////
	// Command pipelines and write capture
	////////////////////////////////////////////////////////////

	always @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int k = 1; k <= rd_depth; k++)
				rd_valid_sr[k] <= 1'b0;
			for (int k = 1; k <= wr_depth; k++)
				wr_valid_sr[k] <= 1'b0;
		end
		else
		begin
			// Word j of a write is on the bus write_latency+j cycles after its command
			for (int j = 0; j < bl; j++)
				if (wr_valid_sr[wl + j])
					mem[wr_addr_sr[wl + j]][j*dw +: dw] <= mem_wdata;

			// A read takes the burst as it stands when the command arrives
			rd_valid_sr[1] <= !mem_read_n;
			rd_burst_sr[1] <= mem[mem_addr];
			wr_valid_sr[1] <= !mem_write_n;
			wr_addr_sr[1] <= mem_addr;
			for (int k = 2; k <= rd_depth; k++)
			begin
				rd_valid_sr[k] <= rd_valid_sr[k-1];
				rd_burst_sr[k] <= rd_burst_sr[k-1];
			end
			for (int k = 2; k <= wr_depth; k++)
			begin
				wr_valid_sr[k] <= wr_valid_sr[k-1];
				wr_addr_sr[k] <= wr_addr_sr[k-1];
			end
		end
	end

	// Word j of a read burst comes back read_latency+j cycles after its command
	always_comb
	begin
		mem_rdata = '0;
		for (int j = 0; j < bl; j++)
			if (rd_valid_sr[rl + j])
				mem_rdata = rd_burst_sr[rl + j][j*dw +: dw];
	end

endmodule

// File: qdrii_memctl.f
source/memctl_timing_pkg.sv
source/memctl_bus_pkg.sv
source/memctl_burst_latency_shifter.sv
source/memctl_cmd_issue.sv
source/memctl_write_path.sv
source/memctl_read_capture.sv
source/qdrii_memctl.sv
bench/qdrii_memory_model.sv
bench/qdrii_memctl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the SRAM controller testbench with Verilator and runs it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f qdrii_memctl.f \
	--top-module qdrii_memctl_tb \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vqdrii_memctl_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with failing status $status"
	exit $status
fi

echo "Simulation finished with status 0"
exit 0

// File: source/memctl_burst_latency_shifter.sv
// Burst latency shifter that stretches a strobe to a burst and delays it through taps
`timescale 1ns/100ps

module memctl_burst_latency_shifter #(
	parameter int max_latency = 3,
	parameter int burst_length = 2
) (
	input logic clk,
	input logic reset_n,
	input logic d,
	output logic [max_latency:0] q
);

	// Wide enough to hold burst_length itself, also for a burst of one
	localparam int cnt_width = $clog2(burst_length + 1);

	logic [cnt_width-1:0] stretch_cnt;
	logic stretched;

	////////////////////////////////////////////////////////////
	// Burst stretch
	////////////////////////////////////////////////////////////

	// The strobe itself covers the first cycle of the burst.
	// The counter then covers the remaining burst_length-1 cycles
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			stretch_cnt <= '0;
		else if (d)
			stretch_cnt <= cnt_width'(burst_length - 1);
		else if (stretch_cnt != '0)
			stretch_cnt <= stretch_cnt - 1'b1;
	end

	// Tap 0 is combinational, so it is high in the cycle of the strobe
	assign stretched = d | (stretch_cnt != '0);

	////////////////////////////////////////////////////////////
	// Latency taps
	////////////////////////////////////////////////////////////

	generate
		if (max_latency == 0)
		begin : gen_no_delay
			assign q[0] = stretched;
		end
		else
		begin : gen_delay
			logic [max_latency:1] tap_reg;

			// Tap k is the stretched strobe seen k cycles later
			assign q = {tap_reg, stretched};

			always_ff @(posedge clk or negedge reset_n)
			begin
				if (!reset_n)
					tap_reg <= '0;
				else
				begin
					tap_reg[1] <= stretched;
					for (int i = 2; i <= max_latency; i++)
						tap_reg[i] <= tap_reg[i-1];
				end
			end
		end
	endgenerate

	// A new strobe must wait until the previous burst has fully stretched,
	// otherwise two bursts would merge into one window
	a_no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
		d |-> (stretch_cnt == '0));

endmodule

// File: source/memctl_bus_pkg.sv
// SRAM controller bus package with address, word and burst widths
package memctl_bus_pkg;

	////////////////////////////////////////////////////////////
	// Memory side widths
	////////////////////////////////////////////////////////////

	// Address of one burst location in the SRAM
	localparam int addr_width = 10;

	// One word on mem_wdata or mem_rdata
	localparam int data_width = 18;

	////////////////////////////////////////////////////////////
	// User side widths
	////////////////////////////////////////////////////////////

	// A whole burst travels on the user data buses in one cycle.
	// Word 0 sits in the lowest bits
	localparam int burst_width = memctl_timing_pkg::burst_length * data_width;

endpackage

// File: source/memctl_cmd_issue.sv
// Command issue for the SRAM controller, accepting user requests and driving command pins
`timescale 1ns/100ps

module memctl_cmd_issue (
	input logic clk,
	input logic reset_n,
	input logic rd_req,
	input logic [memctl_bus_pkg::addr_width-1:0] rd_addr,
	output logic rd_ready,
	input logic wr_req,
	input logic [memctl_bus_pkg::addr_width-1:0] wr_addr,
	output logic wr_ready,
	output logic [memctl_bus_pkg::addr_width-1:0] mem_addr,
	output logic mem_read_n,
	output logic mem_write_n,
	output logic read_issue,
	output logic write_issue
);

	// Holds up to burst_length, the longest write hold-off
	localparam int busy_width = $clog2(memctl_timing_pkg::burst_length + 1);

	logic rd_accept;
	logic wr_accept;
	logic wr_deferred;
	logic [memctl_bus_pkg::addr_width-1:0] wr_addr_hold;
	logic [busy_width-1:0] rd_busy_cnt;
	logic [busy_width-1:0] wr_busy_cnt;

	// A request counts only while its ready level is high
	assign rd_accept = rd_req & rd_ready;
	assign wr_accept = wr_req & wr_ready;

	////////////////////////////////////////////////////////////
	// Command registers
	////////////////////////////////////////////////////////////

	// Reads always go out the cycle after acceptance.
	// A write accepted together with a read is pushed back by one cycle
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_issue <= 1'b0;
			write_issue <= 1'b0;
			wr_deferred <= 1'b0;
		end
		else
		begin
			read_issue <= rd_accept;
			write_issue <= (wr_accept & ~rd_accept) | wr_deferred;
			wr_deferred <= wr_accept & rd_accept;
		end
	end

	// Address pins and the parked write address
	always_ff @(posedge clk)
	begin
		if (rd_accept)
			mem_addr <= rd_addr;
		else if (wr_deferred)
			mem_addr <= wr_addr_hold;
		else if (wr_accept)
			mem_addr <= wr_addr;

		if (wr_accept & rd_accept)
			wr_addr_hold <= wr_addr;
	end

	// Command pins are active low copies of the issue strobes
	assign mem_read_n = ~read_issue;
	assign mem_write_n = ~write_issue;

	////////////////////////////////////////////////////////////
	// Burst spacing
	////////////////////////////////////////////////////////////

	// Each port is held off so that its next command lands burst_length
	// cycles after the previous one. A deferred write needs one more cycle
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			rd_busy_cnt <= '0;
			wr_busy_cnt <= '0;
		end
		else
		begin
			if (rd_accept)
				rd_busy_cnt <= busy_width'(memctl_timing_pkg::burst_length - 1);
			else if (rd_busy_cnt != '0)
				rd_busy_cnt <= rd_busy_cnt - 1'b1;

			if (wr_accept & rd_accept)
				wr_busy_cnt <= busy_width'(memctl_timing_pkg::burst_length);
			else if (wr_accept)
				wr_busy_cnt <= busy_width'(memctl_timing_pkg::burst_length - 1);
			else if (wr_busy_cnt != '0)
				wr_busy_cnt <= wr_busy_cnt - 1'b1;
		end
	end

	assign rd_ready = (rd_busy_cnt == '0);
	assign wr_ready = (wr_busy_cnt == '0);

	// A request may be held through a busy period, but a new one must not start then
	a_rd_req_ready: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(rd_req) |-> rd_ready);
	a_wr_req_ready: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(wr_req) |-> wr_ready);

	// The shared address pins carry only one command per cycle
	a_one_cmd: assert property (@(posedge clk) disable iff (!reset_n)
		!(!mem_read_n && !mem_write_n));

endmodule

// File: source/memctl_read_capture.sv
// Read capture that gathers returning words into a burst and pulses the user read valid
`timescale 1ns/100ps

module memctl_read_capture (
	input logic clk,
	input logic reset_n,
	input logic read_window,
	input logic [memctl_bus_pkg::data_width-1:0] mem_rdata,
	output logic [memctl_bus_pkg::burst_width-1:0] rd_data,
	output logic rd_valid
);

	localparam int idx_width = (memctl_timing_pkg::burst_length > 1) ?
		$clog2(memctl_timing_pkg::burst_length) : 1;

	logic [memctl_bus_pkg::burst_width-1:0] gather_reg;
	logic [idx_width-1:0] word_idx;
	logic last_word;
	logic burst_done;

	// The window of one burst closes after this word, even when the
	// window of the next burst follows straight on
	assign last_word = read_window && (word_idx == idx_width'(memctl_timing_pkg::burst_length - 1));

	////////////////////////////////////////////////////////////
	// Word gathering
	////////////////////////////////////////////////////////////

	// Each word lands in its own slice, word 0 lowest
	always_ff @(posedge clk)
	begin
		if (read_window)
			gather_reg[word_idx * memctl_bus_pkg::data_width +: memctl_bus_pkg::data_width]
				<= mem_rdata;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			word_idx <= '0;
			burst_done <= 1'b0;
		end
		else
		begin
			burst_done <= last_word;
			if (last_word)
				word_idx <= '0;
			else if (read_window)
				word_idx <= word_idx + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// User output
	////////////////////////////////////////////////////////////

	// The complete burst is copied out before the next burst starts
	// overwriting the gather register, so rd_data holds during rd_valid
	always_ff @(posedge clk)
	begin
		if (burst_done)
			rd_data <= gather_reg;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= burst_done;
	end

endmodule

// File: source/memctl_timing_pkg.sv
// SRAM controller timing package with burst length and command-to-data latencies
package memctl_timing_pkg;

	////////////////////////////////////////////////////////////
	// Burst geometry
	////////////////////////////////////////////////////////////

	// Number of memory words moved by one read or write command
	localparam int burst_length = 2;

	////////////////////////////////////////////////////////////
	// Command to data latencies, in clock cycles
	////////////////////////////////////////////////////////////

	// Cycles from the read command to the first word on mem_rdata
	localparam int read_latency = 3;

	// Cycles from the write command to the first word on mem_wdata
	localparam int write_latency = 1;

	// The deepest tap needed by either latency shifter
	localparam int max_latency = (read_latency > write_latency) ?
		read_latency : write_latency;

endpackage

// File: source/memctl_write_path.sv
// Write data path that holds each write burst and serializes it onto the memory bus
`timescale 1ns/100ps

module memctl_write_path (
	input logic clk,
	input logic reset_n,
	input logic write_issue,
	input logic [memctl_bus_pkg::burst_width-1:0] wr_data,
	input logic write_window,
	output logic [memctl_bus_pkg::data_width-1:0] mem_wdata
);

	localparam int idx_width = (memctl_timing_pkg::burst_length > 1) ?
		$clog2(memctl_timing_pkg::burst_length) : 1;

	logic [memctl_bus_pkg::burst_width-1:0] slot_data [2];
	logic load_ptr;
	logic drain_ptr;
	logic [1:0] fill_count;
	logic [idx_width-1:0] word_idx;
	logic burst_end;

	// The last word of the draining burst is on the bus this cycle
	assign burst_end = write_window && (word_idx == idx_width'(memctl_timing_pkg::burst_length - 1));

	////////////////////////////////////////////////////////////
	// Holding slots
	////////////////////////////////////////////////////////////

	// wr_data is taken in the cycle of the write command.
	// A second slot is needed because the next command can load
	// while the last word of the previous burst is still going out
	always_ff @(posedge clk)
	begin
		if (write_issue)
			slot_data[load_ptr] <= wr_data;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			load_ptr <= 1'b0;
			drain_ptr <= 1'b0;
			fill_count <= '0;
			word_idx <= '0;
		end
		else
		begin
			if (write_issue)
				load_ptr <= ~load_ptr;
			if (burst_end)
				drain_ptr <= ~drain_ptr;
			fill_count <= fill_count + {1'b0, write_issue} - {1'b0, burst_end};

			// Word index walks through the burst while the window is open
			if (burst_end)
				word_idx <= '0;
			else if (write_window)
				word_idx <= word_idx + 1'b1;
		end
	end

	// Lowest word of the burst goes out first
	assign mem_wdata = slot_data[drain_ptr][word_idx * memctl_bus_pkg::data_width +:
		memctl_bus_pkg::data_width];

	// Command spacing should never let a third burst arrive before the first has drained
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
		write_issue |-> (fill_count < 2'd2));

endmodule

// File: source/qdrii_memctl.sv
// QDRII-style SRAM controller top level joining command issue, latency shifters and data paths
`timescale 1ns/100ps

module qdrii_memctl (
	input logic clk,
	input logic reset_n,
	// User read port
	input logic rd_req,
	input logic [memctl_bus_pkg::addr_width-1:0] rd_addr,
	output logic rd_ready,
	output logic [memctl_bus_pkg::burst_width-1:0] rd_data,
	output logic rd_valid,
	// User write port
	input logic wr_req,
	input logic [memctl_bus_pkg::addr_width-1:0] wr_addr,
	input logic [memctl_bus_pkg::burst_width-1:0] wr_data,
	output logic wr_ready,
	// Memory side
	output logic [memctl_bus_pkg::addr_width-1:0] mem_addr,
	output logic mem_read_n,
	output logic mem_write_n,
	output logic [memctl_bus_pkg::data_width-1:0] mem_wdata,
	input logic [memctl_bus_pkg::data_width-1:0] mem_rdata
);

	logic read_issue;
	logic write_issue;
	logic [memctl_timing_pkg::max_latency:0] read_taps;
	logic [memctl_timing_pkg::max_latency:0] write_taps;

	////////////////////////////////////////////////////////////
	// Command side
	////////////////////////////////////////////////////////////

	memctl_cmd_issue cmd_issue (
		.clk(clk),
		.reset_n(reset_n),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_ready(rd_ready),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_ready(wr_ready),
		.mem_addr(mem_addr),
		.mem_read_n(mem_read_n),
		.mem_write_n(mem_write_n),
		.read_issue(read_issue),
		.write_issue(write_issue)
	);

	// Turn each command strobe into a burst-long window at every latency
	memctl_burst_latency_shifter #(
		.max_latency(memctl_timing_pkg::max_latency),
		.burst_length(memctl_timing_pkg::burst_length)
	) read_shifter (
		.clk(clk),
		.reset_n(reset_n),
		.d(read_issue),
		.q(read_taps)
	);

	memctl_burst_latency_shifter #(
		.max_latency(memctl_timing_pkg::max_latency),
		.burst_length(memctl_timing_pkg::burst_length)
	) write_shifter (
		.clk(clk),
		.reset_n(reset_n),
		.d(write_issue),
		.q(write_taps)
	);

	////////////////////////////////////////////////////////////
	// Data side
	////////////////////////////////////////////////////////////

	memctl_write_path write_path (
		.clk(clk),
		.reset_n(reset_n),
		.write_issue(write_issue),
		.wr_data(wr_data),
		.write_window(write_taps[memctl_timing_pkg::write_latency]),
		.mem_wdata(mem_wdata)
	);

	memctl_read_capture read_capture (
		.clk(clk),
		.reset_n(reset_n),
		.read_window(read_taps[memctl_timing_pkg::read_latency]),
		.mem_rdata(mem_rdata),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

endmodule
